// File: design/rom_load_defs.svh
/* rom download layout constants */

`ifndef ROM_LOAD_DEFS_SVH
`define ROM_LOAD_DEFS_SVH

// start header, three 16-bit marks in 1 KB units
`define START_BYTES  6
`define START_HEADER 16

// first byte of the bulk image
`define FULL_HEADER  64

// board configuration block
`define CFG_BASE     8              // first config byte address
`define CFG_SIZE     23             // config byte count

// per-region word offsets into sdram, 22 bits
`define CPU_OFFSET   22'h000000
`define SND_OFFSET   22'h040000     // sound cpu rom
`define OKI_OFFSET   22'h050000     // adpcm samples, same bank as sound
`define GFX_OFFSET   22'h000000     // graphics bank starts at zero

// cycles a programming write may wait for its ack
`define ACK_LIMIT    64

`endif

// File: design/sdram_prog_pkg.sv
/* sdram programming write types */

package sdram_prog_pkg;

    // target bank per region
    typedef enum logic [1:0] {
        BANK_SND = 2'b00,       // sound and adpcm
        BANK_CPU = 2'b01,
        BANK_GFX = 2'b10
    } prog_bank_e;

    // one byte write into a 16-bit sdram word
    typedef struct packed {
        logic [21:0] addr;      // word address
        logic [7:0]  data;
        logic [1:0]  mask;      // active low, 10 even byte, 01 odd byte
    } prog_word_t;

endpackage

// File: design/rom_layout_pkg.sv
/* image layout and download phases */

package rom_layout_pkg;

    // bulk image regions, in image order
    typedef enum logic [1:0] {
        REG_CPU = 2'd0,
        REG_SND = 2'd1,
        REG_OKI = 2'd2,         // adpcm sample rom
        REG_GFX = 2'd3
    } region_e;

    // download phases
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_HEADER = 3'd1,       // start marks and reserved bytes
        ST_CFG    = 3'd2,       // configuration block
        ST_BULK   = 3'd3,       // rom data
        ST_DONE   = 3'd4,
        ST_ERROR  = 3'd5        // ack timeout, sticky
    } load_state_e;

    // start marks in 1 KB units, first byte lands in snd_start[7:0]
    typedef struct packed {
        logic [15:0] gfx_start;
        logic [15:0] oki_start;
        logic [15:0] snd_start;
    } region_starts_t;

endpackage

// File: design/prog_bus_if.sv
/* sdram programming write bus */

`timescale 1ns/1ns

interface prog_bus_if;
    import sdram_prog_pkg::*;

    prog_word_t word;           // address, data and byte mask
    prog_bank_e bank;
    logic       we;             // held until ack
    logic       ack;            // from sdram side

    // mapper side
    modport src (
        output word,
        output bank,
        output we,
        input  ack
    );

    // watchdog side, observes only
    modport mon (
        input we,
        input ack
    );

endinterface

// File: design/load_fsm.sv
/* download phase fsm */

`timescale 1ns/1ns
`include "rom_load_defs.svh"

module load_fsm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       downloading,
    input  logic [24:0]                ioctl_addr,
    input  logic                       ioctl_wr,
    input  logic                       timeout,
    output rom_layout_pkg::load_state_e state,
    output logic                       wd_clear,
    output logic                       load_done,
    output logic                       load_error
);
    import rom_layout_pkg::*;

    load_state_e state_next;
    logic        strobe;

    assign strobe = ioctl_wr && downloading;

    always_comb begin
        state_next = state;                         // hold by default
        case (state)
            ST_IDLE: begin
                if (downloading) state_next = ST_HEADER;
            end
            ST_HEADER, ST_CFG, ST_BULK: begin
                if (timeout) begin
                    state_next = ST_ERROR;          // error wins over done
                end else if (!downloading) begin
                    state_next = ST_DONE;
                end else if (strobe && ioctl_addr >= 25'(`FULL_HEADER)) begin
                    state_next = ST_BULK;
                end else if (state == ST_HEADER && strobe &&
                             ioctl_addr >= 25'(`CFG_BASE)) begin
                    state_next = ST_CFG;
                end
            end
            ST_DONE: begin
                if (timeout) state_next = ST_ERROR;
                else if (downloading) state_next = ST_HEADER;   // new image
            end
            ST_ERROR: state_next = ST_ERROR;        // only reset leaves
            default:  state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            wd_clear   <= 1'b0;
            load_done  <= 1'b0;
            load_error <= 1'b0;
        end else begin
            state      <= state_next;
            wd_clear   <= state_next != state;      // one pulse per phase change
            load_done  <= state_next == ST_DONE;
            load_error <= state_next == ST_ERROR;   // sticky via ERROR state
        end
    end

endmodule

// File: design/ack_watchdog.sv
/* programming write ack watchdog */

`timescale 1ns/1ns
`include "rom_load_defs.svh"

module ack_watchdog (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           clear,
    prog_bus_if.mon        bus,
    output logic           timeout
);
    localparam int CW = $clog2(`ACK_LIMIT + 1);

    logic [CW-1:0] cnt;         // unacked write cycles
    logic          at_limit;

    assign at_limit = cnt == CW'(`ACK_LIMIT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (clear || bus.ack) begin
            cnt <= '0;                              // ack or phase change restarts
        end else if (bus.we && !at_limit) begin
            cnt <= cnt + 1'b1;                      // saturates at limit
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timeout <= 1'b0;
        end else if (clear || bus.ack) begin
            timeout <= 1'b0;
        end else begin
            // flag in the cycle the count reaches the limit
            timeout <= at_limit || (bus.we && cnt == CW'(`ACK_LIMIT - 1));
        end
    end

endmodule

// File: design/region_mapper.sv
/* header capture and bulk region mapper */

`timescale 1ns/1ns
`include "rom_load_defs.svh"

module region_mapper (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  logic [24:0]                 ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  logic                        ioctl_wr,
    input  rom_layout_pkg::load_state_e state,
    prog_bus_if.src                     bus,
    output logic                        cfg_we
);
    import rom_layout_pkg::*;
    import sdram_prog_pkg::*;

    region_starts_t starts;
    region_e        region;
    logic [24:0]    bulk_addr;      // offset from bulk start
    logic [15:0]    kb_idx;         // 1 KB index of bulk_addr
    logic [15:0]    base;           // start mark of the region
    logic [21:0]    offset;
    logic [24:0]    rel_addr;       // byte offset inside region
    logic [21:0]    word_addr;
    prog_bank_e     bank;
    logic           strobe;
    logic           blocked;        // no writes outside an active download
    logic           is_start;
    logic           is_cfg;
    logic           is_bulk;

    assign strobe   = ioctl_wr && downloading;
    assign blocked  = state == ST_IDLE || state == ST_DONE || state == ST_ERROR;
    assign is_start = ioctl_addr < 25'(`START_BYTES);
    assign is_cfg   = ioctl_addr >= 25'(`CFG_BASE) &&
                      ioctl_addr < 25'(`CFG_SIZE + `START_HEADER);
    assign is_bulk  = ioctl_addr >= 25'(`FULL_HEADER);

    assign bulk_addr = ioctl_addr - 25'(`FULL_HEADER);
    assign kb_idx    = {1'b0, bulk_addr[24:10]};

    always_comb begin
        if (kb_idx < starts.snd_start)      region = REG_CPU;
        else if (kb_idx < starts.oki_start) region = REG_SND;
        else if (kb_idx < starts.gfx_start) region = REG_OKI;
        else                                region = REG_GFX;

        case (region)
            REG_CPU: begin base = 16'd0;            offset = `CPU_OFFSET; bank = BANK_CPU; end
            REG_SND: begin base = starts.snd_start; offset = `SND_OFFSET; bank = BANK_SND; end
            REG_OKI: begin base = starts.oki_start; offset = `OKI_OFFSET; bank = BANK_SND; end
            default: begin base = starts.gfx_start; offset = `GFX_OFFSET; bank = BANK_GFX; end
        endcase
    end

    assign rel_addr  = bulk_addr - {base[14:0], 10'd0};
    assign word_addr = rel_addr[22:1] + offset;     // bytes to 16-bit words

    // control: start marks, strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            starts <= '0;
            cfg_we <= 1'b0;
            bus.we <= 1'b0;
        end else begin
            cfg_we <= 1'b0;                         // single cycle pulse
            if (strobe && is_start) begin
                starts <= region_starts_t'({ioctl_data, starts[47:8]});
            end
            if (strobe && !blocked) begin
                cfg_we <= is_cfg;
                bus.we <= is_bulk;                  // new strobe overwrites
            end else if (blocked || !downloading || bus.ack) begin
                bus.we <= 1'b0;
            end
        end
    end

    // payload, loaded with every bulk strobe
    always_ff @(posedge clk) begin
        if (strobe && is_bulk) begin
            bus.word <= '{addr: word_addr,
                          data: ioctl_data,
                          mask: ioctl_addr[0] ? 2'b01 : 2'b10};
            bus.bank <= bank;
        end
    end

endmodule

// File: design/cfg_regs.sv
/* board configuration byte bank */

`timescale 1ns/1ns
`include "rom_load_defs.svh"

module cfg_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_we,
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_data,
    output logic [`CFG_SIZE*8-1:0]   cfg_bytes
);
    logic [24:0] idx;               // byte index inside the bank

    // host holds address and data until its next strobe
    assign idx = ioctl_addr - 25'(`CFG_BASE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_bytes <= '0;
        end else if (cfg_we) begin
            for (int i = 0; i < `CFG_SIZE; i++) begin
                if (idx == 25'(i)) begin
                    cfg_bytes[i*8 +: 8] <= ioctl_data;  // byte i at bits 8i
                end
            end
        end
    end

endmodule

// File: design/rom_loader.sv
/* rom download path top */

`timescale 1ns/1ns
`include "rom_load_defs.svh"

module rom_loader (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     downloading,
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    output logic [21:0]              prog_addr,
    output logic [7:0]               prog_data,
    output logic [1:0]               prog_mask,
    output logic [1:0]               prog_bank,
    output logic                     prog_we,
    input  logic                     sdram_ack,
    output logic [`CFG_SIZE*8-1:0]   cfg_bytes,
    output logic                     load_done,
    output logic                     load_error
);
    import rom_layout_pkg::*;

    load_state_e state;
    logic        wd_clear;
    logic        timeout;
    logic        cfg_we;

    prog_bus_if prog_bus ();

    assign prog_bus.ack = sdram_ack;
    assign prog_addr    = prog_bus.word.addr;
    assign prog_data    = prog_bus.word.data;
    assign prog_mask    = prog_bus.word.mask;
    assign prog_bank    = prog_bus.bank;
    assign prog_we      = prog_bus.we;

    load_fsm u_fsm (
        .clk, .rst_n, .downloading, .ioctl_addr, .ioctl_wr,
        .timeout, .state, .wd_clear, .load_done, .load_error
    );

    ack_watchdog u_wdog (
        .clk, .rst_n,
        .clear   (wd_clear),
        .bus     (prog_bus.mon),
        .timeout
    );

    region_mapper u_mapper (
        .clk, .rst_n, .downloading, .ioctl_addr, .ioctl_data, .ioctl_wr,
        .state,
        .bus     (prog_bus.src),
        .cfg_we
    );

    cfg_regs u_cfg (
        .clk, .rst_n, .cfg_we, .ioctl_addr, .ioctl_data, .cfg_bytes
    );

endmodule

// File: verif/rom_loader_tb.sv
/* rom loader testbench */

`timescale 1ns/1ns
`include "rom_load_defs.svh"

module rom_loader_tb;
    import rom_layout_pkg::*;
    import sdram_prog_pkg::*;

    localparam int REC_WORDS = 6;           // kind addr data exp_addr exp_mask exp_bank
    localparam int MAX_RECS  = 64;
    localparam int ACK_WAIT  = 4;           // cycles for prog_we to drop after ack
    localparam int END_WAIT  = 8;           // cycles for load_done or load_error

    localparam logic [31:0] K_LEVEL = 32'h1;    // downloading level
    localparam logic [31:0] K_BYTE  = 32'h2;    // header or config byte
    localparam logic [31:0] K_BULK  = 32'h3;    // bulk byte with expected word
    localparam logic [31:0] K_NOACK = 32'h4;    // next bulk write stays unacked
    localparam logic [31:0] K_END   = 32'h5;    // expected final state
    localparam logic [31:0] K_STOP  = 32'hf;

    logic                   clk;
    logic                   rst_n;
    logic                   downloading;
    logic [24:0]            ioctl_addr;
    logic [7:0]             ioctl_data;
    logic                   ioctl_wr;
    logic [21:0]            prog_addr;
    logic [7:0]             prog_data;
    logic [1:0]             prog_mask;
    logic [1:0]             prog_bank;
    logic                   prog_we;
    logic                   sdram_ack;
    logic [`CFG_SIZE*8-1:0] cfg_bytes;
    logic                   load_done;
    logic                   load_error;

    logic [31:0]            stim [0:REC_WORDS*MAX_RECS-1];
    logic [`CFG_SIZE*8-1:0] cfg_model;      // expected config bank
    logic                   skip_ack;       // armed by a no ack record
    logic                   in_error;       // dut has flagged a timeout

    rom_loader uut (
        .clk, .rst_n, .downloading, .ioctl_addr, .ioctl_data, .ioctl_wr,
        .prog_addr, .prog_data, .prog_mask, .prog_bank, .prog_we,
        .sdram_ack, .cfg_bytes, .load_done, .load_error
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string what, input prog_word_t got, input prog_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s addr=%h data=%h mask=%b, %s",
                      $time, what, got.addr, got.data, got.mask,
                      $sformatf("expected addr=%h data=%h mask=%b",
                                exp.addr, exp.data, exp.mask)));
        end
    endtask

    task automatic check_bank(input string what, input prog_bank_e got, input prog_bank_e exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s bank=%b (%s), expected %s",
                      $time, what, got, got.name(), exp.name()));
        end
    endtask

    task automatic check_bytes(input string what, input logic [`CFG_SIZE*8-1:0] got,
                               input logic [`CFG_SIZE*8-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s cfg_bytes=%h, expected %h",
                      $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                      $time, what, got, exp));
        end
    endtask

    // host strobe with address and data held afterwards
    task automatic strobe_byte(input logic [24:0] addr, input logic [7:0] data);
        @(posedge clk);
        ioctl_addr <= addr;
        ioctl_data <= data;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
    endtask

    task automatic set_level(input logic level);
        @(posedge clk);
        downloading <= level;
        repeat (2) @(posedge clk);          // let the fsm change phase
    endtask

    task automatic byte_write(input logic [24:0] addr, input logic [7:0] data);
        int idx;
        idx = int'(addr) - `CFG_BASE;
        strobe_byte(addr, data);
        @(negedge clk);
        check_flag($sformatf("prog_we after byte at %h", addr), prog_we, 1'b0);
        if (!in_error && idx >= 0 && idx < `CFG_SIZE) begin
            cfg_model[idx*8 +: 8] = data;   // index is address minus 8
        end
        @(negedge clk);                     // bank updates a cycle after cfg_we
        check_bytes($sformatf("config after byte at %h", addr), cfg_bytes, cfg_model);
    endtask

    // prog_we must hold through a random ack delay
    task automatic acknowledge_write();
        int delay;
        int n;
        delay = 1 + int'($urandom % 5);
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            check_flag("prog_we before ack", prog_we, 1'b1);
        end
        @(posedge clk);
        sdram_ack <= 1'b1;
        n = 0;
        @(negedge clk);
        while (prog_we !== 1'b0) begin
            n++;
            if (n == ACK_WAIT) abort_run("timeout: prog_we did not fall after sdram_ack");
            @(negedge clk);
        end
        @(posedge clk);
        sdram_ack <= 1'b0;
    endtask

    task automatic wait_for_error();
        int n;
        n = 0;
        while (load_error !== 1'b1) begin
            if (n == `ACK_LIMIT + 4) begin
                abort_run("timeout: load_error not raised for an unacknowledged write");
            end
            @(negedge clk);
            n++;
        end
        in_error = 1'b1;
        @(negedge clk);
        check_flag("prog_we after watchdog timeout", prog_we, 1'b0);
    endtask

    task automatic bulk_write(input logic [24:0] addr, input logic [7:0] data,
                              input logic [21:0] exp_addr, input logic [1:0] exp_mask,
                              input prog_bank_e exp_bank);
        prog_word_t exp_word;
        prog_word_t got_word;
        exp_word.addr = exp_addr;
        exp_word.data = data;
        exp_word.mask = exp_mask;
        strobe_byte(addr, data);
        @(negedge clk);
        if (in_error) begin
            check_flag($sformatf("prog_we for %h in error", addr), prog_we, 1'b0);
        end else begin
            got_word.addr = prog_addr;
            got_word.data = prog_data;
            got_word.mask = prog_mask;
            check_flag($sformatf("prog_we for %h", addr), prog_we, 1'b1);
            check_word($sformatf("bulk %h", addr), got_word, exp_word);
            check_bank($sformatf("bulk %h", addr), prog_bank_e'(prog_bank), exp_bank);
            if (skip_ack) wait_for_error();
            else acknowledge_write();
        end
        skip_ack = 1'b0;
    endtask

    task automatic end_check(input load_state_e st);
        int n;
        n = 0;
        @(negedge clk);
        while (((st == ST_DONE) ? load_done : load_error) !== 1'b1) begin
            n++;
            if (n == END_WAIT) abort_run("timeout: final load flag did not rise");
            @(negedge clk);
        end
        if (st == ST_DONE) begin
            check_flag("load_error at end", load_error, 1'b0);
        end else begin
            check_flag("load_done at end", load_done, 1'b0);
        end
        check_flag("prog_we at end", prog_we, 1'b0);
    endtask

    initial begin
        int          rec;
        int          base;
        logic [31:0] kind;
        logic        finished;
        void'($urandom(89));
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        sdram_ack   = 1'b0;
        cfg_model   = '0;
        skip_ack    = 1'b0;
        in_error    = 1'b0;
        $readmemh("verif/rom_load_input.txt", stim);
        if ($isunknown(stim[0]) || stim[0] == 32'h0) begin
            abort_run("stimulus file verif/rom_load_input.txt could not be read");
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("prog_we after reset", prog_we, 1'b0);
        check_flag("load_done after reset", load_done, 1'b0);
        check_flag("load_error after reset", load_error, 1'b0);

        rec      = 0;
        finished = 1'b0;
        while (!finished) begin
            if (rec == MAX_RECS) abort_run("stimulus file has no stop record");
            base = rec * REC_WORDS;
            kind = stim[base];
            case (kind)
                K_LEVEL: set_level(stim[base+1][0]);
                K_BYTE:  byte_write(stim[base+1][24:0], stim[base+2][7:0]);
                K_BULK:  bulk_write(stim[base+1][24:0], stim[base+2][7:0],
                                    stim[base+3][21:0], stim[base+4][1:0],
                                    prog_bank_e'(stim[base+5][1:0]));
                K_NOACK: skip_ack = 1'b1;
                K_END:   end_check(load_state_e'(stim[base+1][2:0]));
                K_STOP:  finished = 1'b1;
                default: abort_run($sformatf("unknown record kind %h in record %0d", kind, rec));
            endcase
            rec++;
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verif/rom_load_input.txt
// six hex words per record: kind addr data exp_addr exp_mask exp_bank
// kind 1 level, 2 byte, 3 bulk, 4 no ack, 5 end state, f stop
1 1    00 00000 0 0     // first image
2 0    04 00000 0 0     // snd_start 4 KB
2 1    00 00000 0 0
2 2    08 00000 0 0     // oki_start 8 KB
2 3    00 00000 0 0
2 4    10 00000 0 0     // gfx_start 16 KB
2 5    00 00000 0 0
2 6    a5 00000 0 0     // unused header bytes
2 7    5a 00000 0 0
2 8    11 00000 0 0     // config index 0
2 9    22 00000 0 0
2 c    33 00000 0 0
2 13   44 00000 0 0
2 1e   55 00000 0 0     // last config index
2 8    66 00000 0 0     // overwrite index 0
3 40   c3 00000 2 1     // cpu region
3 41   3c 00000 1 1
3 a3   77 00031 1 1
3 c40  81 00600 2 1     // last kb before sound
3 103f 82 007ff 1 1
3 1040 90 40000 2 0     // sound region
3 1043 91 40001 1 0
3 203e 92 407ff 2 0     // last kb before samples
3 2040 a0 50000 2 0     // adpcm samples
3 2045 a1 50002 1 0
3 403f a2 50fff 1 0     // last kb before graphics
3 4040 b0 00000 2 2     // graphics
3 4041 b1 00000 1 2
3 4840 b2 00400 2 2
1 0    00 00000 0 0     // end of first image
5 4    00 00000 0 0     // expect done
1 1    00 00000 0 0     // second image, same start marks
3 4842 b3 00401 2 2
4 0    00 00000 0 0     // sdram never acks the next write
3 4844 b4 00402 2 2
3 4846 b5 00403 2 2     // blocked in error
2 a    77 00000 0 0     // config blocked in error
1 0    00 00000 0 0
5 5    00 00000 0 0     // expect error
f 0    00 00000 0 0

// File: filelist.f
+incdir+design
design/sdram_prog_pkg.sv
design/rom_layout_pkg.sv
design/prog_bus_if.sv
design/load_fsm.sv
design/ack_watchdog.sv
design/region_mapper.sv
design/cfg_regs.sv
design/rom_loader.sv
verif/rom_loader_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ns
TOP       := rom_loader_tb
FILELIST  := filelist.f
OBJDIR    := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJDIR)
